// File: design/csr_pkg.sv
// RV64 machine-mode CSR map; width, addresses and reset values are fixed, no S or U mode
`default_nettype none

package csr_pkg;

  localparam int xlen = 64;

  typedef logic [11:0]     csr_addr_t;
  typedef logic [xlen-1:0] csr_word_t;

  // Machine trap setup
  localparam csr_addr_t addr_mstatus   = 12'h300;
  localparam csr_addr_t addr_misa      = 12'h301;
  localparam csr_addr_t addr_mie       = 12'h304;
  localparam csr_addr_t addr_mtvec     = 12'h305;

  // Machine trap handling
  localparam csr_addr_t addr_mscratch  = 12'h340;
  localparam csr_addr_t addr_mepc      = 12'h341;
  localparam csr_addr_t addr_mcause    = 12'h342;
  localparam csr_addr_t addr_mtval     = 12'h343;
  localparam csr_addr_t addr_mip       = 12'h344;

  localparam csr_addr_t addr_mcycle    = 12'hB00;  // Only counter implemented

  // Read-only machine information, all hardwired to zero
  localparam csr_addr_t addr_mvendorid = 12'hF11;
  localparam csr_addr_t addr_marchid   = 12'hF12;
  localparam csr_addr_t addr_mimpid    = 12'hF13;
  localparam csr_addr_t addr_mhartid   = 12'hF14;

  // Reset values, every other register clears to zero
  localparam csr_word_t rst_mstatus = 64'h1888;  // MPP=3, MPIE and MIE set
  localparam csr_word_t rst_mie     = 64'h888;

  localparam csr_word_t misa_value = 64'h8000_0000_0000_0100;  // MXL=2, I only

  // Decode stage read port, answered in the same cycle
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
  } csr_rd_req_t;

  // Writeback stage write port
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_word_t data;
  } csr_wr_req_t;

  // Diff view, value each register holds after the coming edge
  typedef struct packed {
    csr_word_t mstatus;
    csr_word_t mepc;
    csr_word_t mtval;
    csr_word_t mtvec;
    csr_word_t mcause;
    csr_word_t mip;
    csr_word_t mie;
    csr_word_t mscratch;
  } csr_view_t;

endpackage

`default_nettype wire

// File: design/csr_regfile.sv
// Machine CSRs only; mip has no interrupt source, writes to read-only or unknown CSRs are dropped
`default_nettype none

module csr_regfile (
  input  wire                           clk,
  input  wire                           rst,
  input  wire csr_pkg::csr_rd_req_t     csr_rd_req,
  input  wire csr_pkg::csr_wr_req_t     csr_wr_req,
  input  wire trap_pkg::trap_wr_t       trap_wr,
  input  wire                           trap_enter,
  input  wire                           trap_exit,
  output logic [csr_pkg::xlen-1:0]      csr_rd_data,
  output trap_pkg::trap_rd_t            trap_rd,
  output csr_pkg::csr_view_t            csr_view
);

  import csr_pkg::*;
  import trap_pkg::*;

  // Storage image, one field per writable CSR
  typedef struct packed {
    mstatus_t  mstatus;
    csr_word_t mie;
    csr_word_t mtvec;
    csr_word_t mscratch;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;
    csr_word_t mip;
    csr_word_t mcycle;
  } csr_state_t;

  // Decoded write strobes
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mip;
    logic mcycle;
  } csr_sel_t;

  csr_state_t state_q;
  csr_state_t state_d;   // Also the bypass source for the view bus
  csr_sel_t   wr_sel;
  csr_word_t  rd_word;
  logic       trap_any;

  assign trap_any = trap_enter | trap_exit;

  // Write address decode
  always_comb begin
    wr_sel = '0;
    if (csr_wr_req.en) begin
      case (csr_wr_req.addr)
        addr_mstatus:  wr_sel.mstatus  = 1'b1;
        addr_mie:      wr_sel.mie      = 1'b1;
        addr_mtvec:    wr_sel.mtvec    = 1'b1;
        addr_mscratch: wr_sel.mscratch = 1'b1;
        addr_mepc:     wr_sel.mepc     = 1'b1;
        addr_mcause:   wr_sel.mcause   = 1'b1;
        addr_mtval:    wr_sel.mtval    = 1'b1;
        addr_mip:      wr_sel.mip      = 1'b1;
        addr_mcycle:   wr_sel.mcycle   = 1'b1;
        default:       wr_sel          = '0;  // misa, ID registers, unmapped
      endcase
    end
  end

  // Next value of every register
  always_comb begin
    state_d        = state_q;
    state_d.mcycle = state_q.mcycle + xlen'(1);  // Free running

    if (wr_sel.mstatus)  state_d.mstatus.raw = csr_wr_req.data;
    if (wr_sel.mie)      state_d.mie         = csr_wr_req.data;
    if (wr_sel.mtvec)    state_d.mtvec       = csr_wr_req.data;
    if (wr_sel.mscratch) state_d.mscratch    = csr_wr_req.data;
    if (wr_sel.mepc)     state_d.mepc        = csr_wr_req.data;
    if (wr_sel.mcause)   state_d.mcause      = csr_wr_req.data;
    if (wr_sel.mtval)    state_d.mtval       = csr_wr_req.data;
    if (wr_sel.mip)      state_d.mip         = csr_wr_req.data;
    if (wr_sel.mcycle)   state_d.mcycle      = csr_wr_req.data;  // Load instead of count

    // Trap updates override a CSR write in the same cycle
    if (trap_any) begin
      state_d.mstatus = trap_wr.mstatus;
    end
    // On a return mepc, mcause and mtval hold their stored values
    if (trap_enter) begin
      state_d.mepc   = trap_wr.mepc;
      state_d.mcause = trap_wr.mcause;
      state_d.mtval  = trap_wr.mtval;
    end else if (trap_exit) begin
      state_d.mepc   = state_q.mepc;
      state_d.mcause = state_q.mcause;
      state_d.mtval  = state_q.mtval;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q             <= '0;
      state_q.mstatus.raw <= rst_mstatus;
      state_q.mie         <= rst_mie;
    end else begin
      state_q <= state_d;
    end
  end

  // Read mux over stored values
  always_comb begin
    case (csr_rd_req.addr)
      addr_mstatus:   rd_word = state_q.mstatus.raw;
      addr_misa:      rd_word = misa_value;
      addr_mie:       rd_word = state_q.mie;
      addr_mtvec:     rd_word = state_q.mtvec;
      addr_mscratch:  rd_word = state_q.mscratch;
      addr_mepc:      rd_word = state_q.mepc;
      addr_mcause:    rd_word = state_q.mcause;
      addr_mtval:     rd_word = state_q.mtval;
      addr_mip:       rd_word = state_q.mip;
      addr_mcycle:    rd_word = state_q.mcycle;
      // Single hart, no vendor or implementation number
      addr_mvendorid: rd_word = '0;
      addr_marchid:   rd_word = '0;
      addr_mimpid:    rd_word = '0;
      addr_mhartid:   rd_word = '0;
      default:        rd_word = '0;
    endcase
  end

  assign csr_rd_data = (csr_rd_req.en && !rst) ? rd_word : '0;

  // Trap unit sees what is stored, not the bypass
  assign trap_rd.mstatus = state_q.mstatus;
  assign trap_rd.mtvec   = state_q.mtvec;
  assign trap_rd.mepc    = state_q.mepc;

  assign csr_view.mstatus  = state_d.mstatus.raw;
  assign csr_view.mepc     = state_d.mepc;
  assign csr_view.mtval    = state_d.mtval;
  assign csr_view.mtvec    = state_d.mtvec;
  assign csr_view.mcause   = state_d.mcause;
  assign csr_view.mip      = state_d.mip;
  assign csr_view.mie      = state_d.mie;
  assign csr_view.mscratch = state_d.mscratch;

endmodule

`default_nettype wire

// File: design/csr_subsystem.sv
// Top of the machine CSR block; no back-pressure, every control input is a one-cycle strobe
`default_nettype none

module csr_subsystem (
  input  wire                           clk,
  input  wire                           rst,
  input  wire csr_pkg::csr_rd_req_t     csr_rd_req,
  input  wire csr_pkg::csr_wr_req_t     csr_wr_req,
  input  wire trap_pkg::trap_req_t      trap_req,
  output logic [csr_pkg::xlen-1:0]      csr_rd_data,
  output logic [csr_pkg::xlen-1:0]      trap_pc,
  output logic                          trap_valid,
  output csr_pkg::csr_view_t            csr_view
);

  import trap_pkg::*;

  trap_rd_t trap_rd;     // Stored mstatus, mtvec, mepc
  trap_wr_t trap_wr;     // Exception write bus
  logic     trap_enter;
  logic     trap_exit;   // Already masked by enter

  trap_unit u_trap_unit (
    .trap_req   (trap_req),
    .trap_rd    (trap_rd),
    .trap_wr    (trap_wr),
    .trap_enter (trap_enter),
    .trap_exit  (trap_exit),
    .trap_valid (trap_valid),
    .trap_pc    (trap_pc)
  );

  csr_regfile u_csr_regfile (
    .clk         (clk),
    .rst         (rst),
    .csr_rd_req  (csr_rd_req),
    .csr_wr_req  (csr_wr_req),
    .trap_wr     (trap_wr),
    .trap_enter  (trap_enter),
    .trap_exit   (trap_exit),
    .csr_rd_data (csr_rd_data),
    .trap_rd     (trap_rd),
    .csr_view    (csr_view)
  );

endmodule

`default_nettype wire

// File: design/trap_pkg.sv
// Machine-mode trap types; only mie, mpie and mpp of mstatus are touched by trap logic
`default_nettype none

package trap_pkg;

  // Exception codes driven by the pipeline
  localparam csr_pkg::csr_word_t cause_illegal_instr = 64'd2;
  localparam csr_pkg::csr_word_t cause_breakpoint    = 64'd3;
  localparam csr_pkg::csr_word_t cause_ecall_m       = 64'd11;

  localparam logic [1:0] mpp_machine = 2'b11;

  // Field layout of mstatus as seen by the trap logic
  typedef struct packed {
    logic [50:0] rsvd_hi;   // 63:13
    logic [1:0]  mpp;       // 12:11
    logic [2:0]  rsvd_mid;  // 10:8
    logic        mpie;      // 7
    logic [2:0]  rsvd_lo;   // 6:4
    logic        mie;       // 3
    logic [2:0]  rsvd_ls;   // 2:0
  } mstatus_fields_t;

  // Same word, written raw by CSR instructions and by field on a trap
  typedef union packed {
    csr_pkg::csr_word_t raw;
    mstatus_fields_t    f;
  } mstatus_t;

  // Pulses and payload from the pipeline
  typedef struct packed {
    logic               enter;
    logic               exit;
    csr_pkg::csr_word_t pc;
    csr_pkg::csr_word_t cause;
    csr_pkg::csr_word_t tval;
  } trap_req_t;

  // Exception write bus into the CSR file
  typedef struct packed {
    mstatus_t           mstatus;
    csr_pkg::csr_word_t mepc;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mtval;
  } trap_wr_t;

  // Exception read bus, stored values only
  typedef struct packed {
    mstatus_t           mstatus;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mepc;
  } trap_rd_t;

endpackage

`default_nettype wire

// File: design/trap_unit.sv
// Machine mode and direct mtvec only; enter wins when enter and exit pulse together
`default_nettype none

module trap_unit (
  input  wire trap_pkg::trap_req_t   trap_req,
  input  wire trap_pkg::trap_rd_t    trap_rd,
  output trap_pkg::trap_wr_t         trap_wr,
  output logic                       trap_enter,
  output logic                       trap_exit,
  output logic                       trap_valid,
  output logic [csr_pkg::xlen-1:0]   trap_pc
);

  import csr_pkg::*;
  import trap_pkg::*;

  mstatus_t        status_nxt;
  logic [xlen-1:0] vec_base;

  // Priority between the two pulses
  assign trap_enter = trap_req.enter;
  assign trap_exit  = trap_req.exit & ~trap_req.enter;
  assign trap_valid = trap_req.enter | trap_req.exit;

  // mstatus stack update, other bits pass through untouched
  always_comb begin
    status_nxt = trap_rd.mstatus;
    if (trap_enter) begin
      status_nxt.f.mpie = trap_rd.mstatus.f.mie;  // Save interrupt enable
      status_nxt.f.mie  = 1'b0;
      status_nxt.f.mpp  = mpp_machine;
    end else if (trap_exit) begin
      status_nxt.f.mie  = trap_rd.mstatus.f.mpie;  // Restore
      status_nxt.f.mpie = 1'b1;
      status_nxt.f.mpp  = mpp_machine;            // No lower mode to drop to
    end
  end

  assign trap_wr.mstatus = status_nxt;
  assign trap_wr.mepc    = trap_req.pc;
  assign trap_wr.mcause  = trap_req.cause;
  assign trap_wr.mtval   = trap_req.tval;

  // Direct mode, MODE bits are dropped from the base
  assign vec_base = {trap_rd.mtvec[xlen-1:2], 2'b00};

  // Redirect target
  always_comb begin
    if (trap_enter) begin
      trap_pc = vec_base;
    end else if (trap_exit) begin
      trap_pc = trap_rd.mepc;  // mret
    end else begin
      trap_pc = '0;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
design/csr_pkg.sv
design/trap_pkg.sv
design/trap_unit.sv
design/csr_regfile.sv
design/csr_subsystem.sv
tb/csr_checker.sv
tb/csr_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_tb -f flist.f -o csr_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// File: tb/csr_checker.sv
// Bound into csr_subsystem; all properties are sampled on posedge clk and ignored during rst
`default_nettype none

module csr_checker (
  input wire                       clk,
  input wire                       rst,
  input wire csr_pkg::csr_rd_req_t csr_rd_req,
  input wire [csr_pkg::xlen-1:0]   csr_rd_data,
  input wire trap_pkg::trap_req_t  trap_req,
  input wire                       trap_exit,
  input wire                       trap_valid,
  input wire [csr_pkg::xlen-1:0]   trap_pc,
  input wire trap_pkg::trap_rd_t   trap_rd,
  input wire csr_pkg::csr_view_t   csr_view
);

  // Idle read port returns zero
  a_rd_idle_zero: assert property (@(posedge clk) disable iff (rst)
    !csr_rd_req.en |-> csr_rd_data == '0)
    else $error("csr_rd_data nonzero while read enable is low");

  a_valid_match: assert property (@(posedge clk) disable iff (rst)
    trap_valid == (trap_req.enter | trap_req.exit))
    else $error("trap_valid differs from enter or exit");

  // trap_exit is already masked by enter
  a_return_target: assert property (@(posedge clk) disable iff (rst)
    trap_exit |-> trap_pc == csr_view.mepc)
    else $error("Return target differs from mepc");

  // Stored mstatus, one cycle after the entry edge
  a_entry_mie_clear: assert property (@(posedge clk) disable iff (rst)
    trap_req.enter |=> !trap_rd.mstatus.f.mie)
    else $error("mstatus.mie still set after trap entry");

endmodule

`default_nettype wire

// File: tb/csr_tb.sv
// Self-checking testbench for csr_subsystem; LCG stimulus from a fixed seed, needs timing support
`default_nettype none

module csr_tb;

  import csr_pkg::*;
  import trap_pkg::*;

  // Stored register image kept by the reference model
  typedef struct packed {
    csr_word_t mstatus;
    csr_word_t mie;
    csr_word_t mtvec;
    csr_word_t mscratch;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;
    csr_word_t mip;
    csr_word_t mcycle;
  } model_t;

  logic        clk;
  logic        rst;
  csr_rd_req_t rd_req;
  csr_wr_req_t wr_req;
  trap_req_t   t_req;
  csr_word_t   rd_data;
  csr_word_t   trap_pc;
  logic        trap_valid;
  csr_view_t   view;

  model_t      mdl;
  logic [31:0] seed = 32'hdd74_c061;
  int          errors, test_errors, tests_ok, tests_bad;

  csr_addr_t all_addr [14] = '{addr_mstatus, addr_misa, addr_mie, addr_mtvec, addr_mscratch,
                               addr_mepc, addr_mcause, addr_mtval, addr_mip, addr_mcycle,
                               addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid};
  csr_addr_t rw_addr [8]   = '{addr_mie, addr_mtvec, addr_mscratch, addr_mepc, addr_mcause,
                               addr_mtval, addr_mip, addr_mstatus};
  csr_addr_t ro_addr [5]   = '{addr_misa, addr_mvendorid, addr_marchid, addr_mimpid,
                               addr_mhartid};
  csr_word_t causes [3]    = '{cause_illegal_instr, cause_breakpoint, cause_ecall_m};

  csr_subsystem dut (
    .clk         (clk),
    .rst         (rst),
    .csr_rd_req  (rd_req),
    .csr_wr_req  (wr_req),
    .trap_req    (t_req),
    .csr_rd_data (rd_data),
    .trap_pc     (trap_pc),
    .trap_valid  (trap_valid),
    .csr_view    (view)
  );

  bind csr_subsystem csr_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .csr_rd_req  (csr_rd_req),
    .csr_rd_data (csr_rd_data),
    .trap_req    (trap_req),
    .trap_exit   (trap_exit),
    .trap_valid  (trap_valid),
    .trap_pc     (trap_pc),
    .trap_rd     (trap_rd),
    .csr_view    (csr_view)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = rand32();
    return r[31];  // Top bit, low LCG bits repeat quickly
  endfunction

  function automatic int pick(input int n);
    return int'((rand32() >> 8) % n);
  endfunction

  function automatic logic is_mapped(input csr_addr_t addr);
    logic hit;
    hit = 1'b0;
    foreach (all_addr[i]) begin
      if (all_addr[i] == addr) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic model_t reset_state();
    model_t s;
    s         = '0;
    s.mstatus = 64'h1888;
    s.mie     = 64'h888;
    return s;
  endfunction

  function automatic csr_word_t expected_read(input model_t s, input csr_addr_t addr);
    csr_word_t v;
    case (addr)
      addr_mstatus:  v = s.mstatus;
      addr_misa:     v = 64'h8000_0000_0000_0100;
      addr_mie:      v = s.mie;
      addr_mtvec:    v = s.mtvec;
      addr_mscratch: v = s.mscratch;
      addr_mepc:     v = s.mepc;
      addr_mcause:   v = s.mcause;
      addr_mtval:    v = s.mtval;
      addr_mip:      v = s.mip;
      addr_mcycle:   v = s.mcycle;
      default:       v = '0;  // ID registers and unmapped
    endcase
    return v;
  endfunction

  // Value after the coming edge, trap fields beat a CSR write
  function automatic model_t next_state(input model_t s, input csr_wr_req_t w,
                                        input trap_req_t t);
    model_t n;
    n        = s;
    n.mcycle = s.mcycle + 64'd1;
    if (w.en) begin
      case (w.addr)
        addr_mstatus:  n.mstatus  = w.data;
        addr_mie:      n.mie      = w.data;
        addr_mtvec:    n.mtvec    = w.data;
        addr_mscratch: n.mscratch = w.data;
        addr_mepc:     n.mepc     = w.data;
        addr_mcause:   n.mcause   = w.data;
        addr_mtval:    n.mtval    = w.data;
        addr_mip:      n.mip      = w.data;
        addr_mcycle:   n.mcycle   = w.data;
        default:       ;  // Read-only and unmapped writes are dropped
      endcase
    end
    if (t.enter) begin
      n.mstatus        = s.mstatus;
      n.mstatus[7]     = s.mstatus[3];  // mpie gets old mie
      n.mstatus[3]     = 1'b0;
      n.mstatus[12:11] = 2'b11;
      n.mepc           = t.pc;
      n.mcause         = t.cause;
      n.mtval          = t.tval;
    end else if (t.exit) begin
      n.mstatus        = s.mstatus;
      n.mstatus[3]     = s.mstatus[7];
      n.mstatus[7]     = 1'b1;
      n.mstatus[12:11] = 2'b11;
      n.mepc           = s.mepc;  // Return keeps the handler state
      n.mcause         = s.mcause;
      n.mtval          = s.mtval;
    end
    return n;
  endfunction

  always @(posedge clk) begin
    if (rst) mdl <= reset_state();
    else     mdl <= next_state(mdl, wr_req, t_req);
  end

  task automatic report_mismatch(input string name, input csr_word_t exp, input csr_word_t act);
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Falling edge, all strobes back to idle
  task automatic next_cycle();
    @(negedge clk);
    rd_req = '0;
    wr_req = '0;
    t_req  = '0;
  endtask

  task automatic read_check(input string name, input csr_addr_t addr);
    csr_word_t exp;
    next_cycle();
    rd_req.en   = 1'b1;
    rd_req.addr = addr;
    #2;
    exp = expected_read(mdl, addr);
    if (rd_data !== exp) report_mismatch(name, exp, rd_data);
  endtask

  task automatic view_check(input string name);
    model_t    nx;
    csr_view_t exp;
    int        i;
    nx = next_state(mdl, wr_req, t_req);
    exp = '{nx.mstatus, nx.mepc, nx.mtval, nx.mtvec, nx.mcause, nx.mip, nx.mie, nx.mscratch};
    for (i = 0; i < 8; i++) begin
      if (view[i*64 +: 64] !== exp[i*64 +: 64]) report_mismatch(name, exp[i*64 +: 64],
                                                                view[i*64 +: 64]);
    end
  endtask

  task automatic random_write();
    wr_req.en   = 1'b1;
    wr_req.addr = rw_addr[pick(8)];
    wr_req.data = {rand32(), rand32()};
  endtask

  task automatic run_tests();
    csr_word_t exp;
    csr_word_t data;
    csr_addr_t addr;
    int        i;
    int        k;
    int        wait_n;
    next_cycle();
    #2;
    if (trap_valid !== 1'b0) report_mismatch("reset_values", 64'd0, {63'd0, trap_valid});
    if (rd_data !== '0) report_mismatch("reset_values", 64'd0, rd_data);
    foreach (all_addr[j]) read_check("reset_values", all_addr[j]);
    finish_test("reset_values");

    for (i = 0; i < 200; i++) begin
      next_cycle();
      if (rand_bit()) random_write();
      rd_req.en   = rand_bit();
      rd_req.addr = all_addr[pick(14)];
      #2;
      exp = rd_req.en ? expected_read(mdl, rd_req.addr) : '0;
      if (rd_data !== exp) report_mismatch("random_rw", exp, rd_data);
      if (rand_bit()) view_check("random_rw view");
    end
    finish_test("random_rw");

    for (i = 0; i < 40; i++) begin
      next_cycle();
      addr = rand_bit() ? ro_addr[pick(5)] : csr_addr_t'(rand32() >> 20);
      // A writable hit is moved to an unmapped address
      if (is_mapped(addr) && addr != addr_misa && addr < addr_mvendorid) addr = 12'h7C0;
      wr_req = '{1'b1, addr, {rand32(), rand32()}};
      rd_req = '{1'b1, addr};
      #2;
      exp = (addr == addr_misa) ? 64'h8000_0000_0000_0100 : '0;
      if (rd_data !== exp) report_mismatch("read_only", exp, rd_data);
    end
    foreach (all_addr[j]) read_check("read_only", all_addr[j]);
    finish_test("read_only");

    for (i = 0; i < 24; i++) begin
      next_cycle();
      random_write();  // Vary mtvec, mstatus and friends between traps
      next_cycle();
      t_req = '{1'b1, 1'b0, {rand32(), rand32()}, causes[pick(3)], {rand32(), rand32()}};
      if (i % 2 == 0) wr_req = '{1'b1, addr_mepc, {rand32(), rand32()}};
      #2;
      exp = {mdl.mtvec[63:2], 2'b00};
      if (trap_pc !== exp) report_mismatch("trap_entry pc", exp, trap_pc);
      if (trap_valid !== 1'b1) report_mismatch("trap_entry valid", 64'd1, {63'd0, trap_valid});
      view_check("trap_entry view");
      read_check("trap_entry mepc", addr_mepc);
      read_check("trap_entry mcause", addr_mcause);
      read_check("trap_entry mtval", addr_mtval);
      read_check("trap_entry mstatus", addr_mstatus);
    end
    finish_test("trap_entry");

    for (i = 0; i < 24; i++) begin
      next_cycle();
      wr_req = '{1'b1, addr_mstatus, {rand32(), rand32()}};  // Random mpie to restore
      next_cycle();
      t_req = '{(i % 4 == 0), 1'b1, {rand32(), rand32()}, causes[pick(3)], {rand32(), rand32()}};
      if (i % 3 == 1) wr_req = '{1'b1, addr_mepc, {rand32(), rand32()}};  // mret keeps mepc
      #2;
      exp = t_req.enter ? {mdl.mtvec[63:2], 2'b00} : mdl.mepc;
      if (trap_pc !== exp) report_mismatch("trap_return pc", exp, trap_pc);
      if (trap_valid !== 1'b1) report_mismatch("trap_return valid", 64'd1, {63'd0, trap_valid});
      view_check("trap_return view");
      read_check("trap_return mstatus", addr_mstatus);
      read_check("trap_return mepc", addr_mepc);
    end
    finish_test("trap_return");

    for (i = 0; i < 12; i++) begin
      next_cycle();
      data   = {rand32(), rand32()};
      wr_req = '{1'b1, addr_mcycle, data};
      wait_n = pick(16) + 1;
      for (k = 0; k < wait_n; k++) begin
        next_cycle();
        if (rand_bit()) random_write();
        #2;
        view_check("mcycle view");
      end
      next_cycle();
      rd_req = '{1'b1, addr_mcycle};
      #2;
      exp = data + 64'(wait_n);  // One count per edge after the load
      if (rd_data !== exp) report_mismatch("mcycle", exp, rd_data);
    end
    finish_test("mcycle");
  endtask

  initial begin
    int n;
    rd_req      = '{1'b1, addr_mstatus};  // Read port held active through reset
    wr_req      = '0;
    t_req       = '0;
    errors      = 0;
    test_errors = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    n           = 0;
    while (rst && n < 64) begin
      @(negedge clk);
      #2;
      if (rst && rd_data !== '0) report_mismatch("reset_read", 64'd0, rd_data);
      n++;
    end
    if (rst) begin
      $display("Timeout: reset was still asserted after 64 cycles");
      $display("TESTS FAILED");
    end else begin
      run_tests();
      $display("Summary: %0d tests clean, %0d tests with errors, %0d mismatches",
               tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
